// ==== flist.f ====
+incdir+common
common/frontend_pkg.sv
fetch/fetch_control.sv
fetch/fetch_pc_counter.sv
logic/inst_buffer.sv
logic/inst_decode.sv
logic/fetch_frontend.sv
verification/fetch_frontend_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert \
    -f flist.f \
    --top-module fetch_frontend_tb \
    -o fetch_frontend_sim \
    > build.log 2>&1 \
    && ./obj_dir/fetch_frontend_sim > sim.log 2>&1 \
    || echo "build or simulation error, see build.log and sim.log"

grep -qx "TB PASSED" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== verification/fetch_frontend_tb.sv ====
`timescale 1ns/1ns
`include "frontend_params.svh"

module fetch_frontend_tb;
    localparam int FW          = `FE_FETCH_WIDTH;
    localparam int DW          = `FE_DISPATCH_WIDTH;
    localparam int DC_BITS     = $clog2(`FE_DISPATCH_WIDTH + 1);
    localparam logic [31:0] GROUP_BYTES = 32'(4 * `FE_FETCH_WIDTH);

    localparam int MODE_RANDOM   = 0;
    localparam int MODE_MAX      = 1;
    localparam int MODE_STALL    = 2;
    localparam int MODE_REDIRECT = 3;

    localparam int BOOT_LEN     = 10;
    localparam int STREAM_LEN   = 300;
    localparam int DECODE_LEN   = 100;
    localparam int STALL_LEN    = 24;
    localparam int RESUME_LEN   = 16;
    localparam int PRESSURE_LEN = 3 * (STALL_LEN + RESUME_LEN);
    localparam int REDIRECT_LEN = 200;
    localparam int TOTAL_LEN    = BOOT_LEN + STREAM_LEN + DECODE_LEN + PRESSURE_LEN
                                  + REDIRECT_LEN;
    localparam int CYCLE_LIMIT  = 4 * TOTAL_LEN;

    logic clock;
    logic reset;
    frontend_pkg::fetch_resp_t mem_resp;
    frontend_pkg::redirect_t redirect;
    logic [DC_BITS-1:0] dispatch_count;
    frontend_pkg::fetch_req_t mem_req;
    frontend_pkg::decoded_inst_t [DW-1:0] dispatch_insts;
    logic [DC_BITS-1:0] dispatch_valid_count;

    // Testbench state
    logic [31:0] rng_state;
    logic [31:0] expected_pc;
    frontend_pkg::fetch_resp_t next_resp;
    int occupancy;
    int stall_run;
    int cycle_count;
    int test_errors;
    int total_errors;
    int tests_run;
    int tests_failed;
    int redirect_count;
    int neg_imm_seen;
    int pos_imm_seen;
    int reg_seen;
    logic first_req_seen;
    logic first_dispatch_seen;

    fetch_frontend fetch_frontend_i (
        .clock               (clock),
        .reset               (reset),
        .mem_resp            (mem_resp),
        .redirect            (redirect),
        .dispatch_count      (dispatch_count),
        .mem_req             (mem_req),
        .dispatch_insts      (dispatch_insts),
        .dispatch_valid_count(dispatch_valid_count)
    );

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Instruction memory contents, a hash of the address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] h;
        h = addr * 32'h9E37_79B1;
        h = h ^ (h >> 15);
        h = h * 32'h85EB_CA6B;
        h = h ^ (h >> 13);
        if (h[0]) begin
            h[6:0] = h[1] ? 7'b0010011 : 7'b0000011;
        end else begin
            h[6:0] = 7'b0110011;
        end
        return h;
    endfunction

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        $display("error at %0t ns: %s = %h, expected %h", $time, name, got, expected);
        test_errors++;
    endtask

    task automatic report_text(input string what);
        $display("failure at %0t ns: %s", $time, what);
        test_errors++;
    endtask

    task automatic check_slot(input frontend_pkg::decoded_inst_t got);
        logic [31:0] w;
        logic        i_type;
        logic [31:0] imm;
        w = mem_word(expected_pc);
        i_type = (w[6:0] == 7'b0010011) || (w[6:0] == 7'b0000011);
        imm = i_type ? {{20{w[31]}}, w[31:20]} : 32'd0;
        if (got.pc !== expected_pc) report_value("dispatch pc", got.pc, expected_pc);
        if (got.word !== w) report_value("dispatch word", got.word, w);
        if (got.opcode !== w[6:0]) report_value("opcode", 32'(got.opcode), 32'(w[6:0]));
        if (got.rd !== w[11:7]) report_value("rd", 32'(got.rd), 32'(w[11:7]));
        if (got.rs1 !== w[19:15]) report_value("rs1", 32'(got.rs1), 32'(w[19:15]));
        if (got.rs2 !== (i_type ? 5'd0 : w[24:20])) begin
            report_value("rs2", 32'(got.rs2), 32'(i_type ? 5'd0 : w[24:20]));
        end
        if (got.is_imm !== i_type) report_value("is_imm", 32'(got.is_imm), 32'(i_type));
        if (got.imm !== imm) report_value("imm", got.imm, imm);
        if (i_type && w[31]) neg_imm_seen++;
        if (i_type && !w[31]) pos_imm_seen++;
        if (!i_type) reg_seen++;
        first_dispatch_seen = 1'b1;
        expected_pc = expected_pc + 32'd4;
    endtask

    task automatic step_cycle(input int mode);
        logic [31:0] r;
        logic [31:0] target;
        logic        do_redirect;
        int          take;
        int          offered;
        @(posedge clock);
        #1;
        mem_resp = next_resp;
        offered = int'(dispatch_valid_count);
        if (offered != ((occupancy < DW) ? occupancy : DW)) begin
            report_value("dispatch_valid_count", 32'(offered),
                         32'((occupancy < DW) ? occupancy : DW));
        end
        if (mode == MODE_STALL && stall_run >= 8 && offered != DW) begin
            report_value("dispatch_valid_count", 32'(offered), 32'(DW));
        end
        r = next_random();
        do_redirect = (mode == MODE_REDIRECT) && (r[31:28] == 4'd0);
        target = (32'h0000_4000 + {20'd0, r[23:12]}) & ~(GROUP_BYTES - 32'd1);
        take = 0;
        if (!do_redirect && mode == MODE_MAX) take = offered;
        if (!do_redirect && (mode == MODE_RANDOM || mode == MODE_REDIRECT)) begin
            take = int'(r[25:24]) % (offered + 1);
        end
        redirect.valid = do_redirect;
        redirect.pc = target;
        dispatch_count = DC_BITS'(take);

        // Outputs settled, well before the next edge
        #5;
        for (int i = 0; i < take; i++) begin
            check_slot(dispatch_insts[i]);
        end
        if (do_redirect) begin
            occupancy = 0;
            expected_pc = target;
            redirect_count++;
        end else begin
            occupancy = occupancy - take + (mem_resp.valid ? FW : 0);
        end
        if (occupancy > `FE_BUF_DEPTH) begin
            report_text("memory response accepted with no room in the buffer");
        end
        next_resp = '0;
        if (mem_req.valid) begin
            if (!first_req_seen && mem_req.addr !== `FE_BOOT_PC) begin
                report_value("mem_req.addr", mem_req.addr, `FE_BOOT_PC);
            end
            if (mode == MODE_STALL && stall_run >= 8) begin
                report_text("fetch request issued while the buffer is full");
            end
            first_req_seen = 1'b1;
            next_resp.valid = 1'b1;
            next_resp.addr = mem_req.addr;
            for (int k = 0; k < FW; k++) begin
                next_resp.words[k] = mem_word(mem_req.addr + 32'(4 * k));
            end
        end
        stall_run = (mode == MODE_STALL) ? stall_run + 1 : 0;
    endtask

    task automatic start_test();
        test_errors = 0;
        redirect_count = 0;
        neg_imm_seen = 0;
        pos_imm_seen = 0;
        reg_seen = 0;
    endtask

    task automatic finish_test(input string name, input int cycles);
        $display("test %s: %0d cycles, %0d errors", name, cycles, test_errors);
        tests_run++;
        if (test_errors != 0) tests_failed++;
        total_errors += test_errors;
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        mem_resp = '0;
        redirect = '0;
        dispatch_count = '0;
        rng_state = 32'h5550;
        expected_pc = `FE_BOOT_PC;
        next_resp = '0;
        occupancy = 0;
        stall_run = 0;
        cycle_count = 0;
        total_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        first_req_seen = 1'b0;
        first_dispatch_seen = 1'b0;

        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;

        start_test();
        #5;
        if (mem_req.valid) report_text("fetch request issued in the reset state");
        if (dispatch_valid_count != '0) begin
            report_value("dispatch_valid_count", 32'(dispatch_valid_count), 32'd0);
        end
        repeat (BOOT_LEN) step_cycle(MODE_MAX);
        if (!first_dispatch_seen) report_text("nothing was dispatched after reset");
        finish_test("boot", BOOT_LEN);

        start_test();
        repeat (STREAM_LEN) step_cycle(MODE_RANDOM);
        finish_test("random_stream", STREAM_LEN);

        start_test();
        repeat (DECODE_LEN) step_cycle(MODE_MAX);
        if (neg_imm_seen == 0 || pos_imm_seen == 0 || reg_seen == 0) begin
            report_text("decode mix missed an I-type sign or the R-type case");
        end
        finish_test("decode_mix", DECODE_LEN);

        start_test();
        repeat (3) begin
            repeat (STALL_LEN) step_cycle(MODE_STALL);
            repeat (RESUME_LEN) step_cycle(MODE_RANDOM);
        end
        finish_test("back_pressure", PRESSURE_LEN);

        start_test();
        repeat (REDIRECT_LEN) step_cycle(MODE_REDIRECT);
        if (redirect_count == 0) report_text("no redirect was exercised");
        finish_test("redirect", REDIRECT_LEN);

        $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed,
                 total_errors);
        if (total_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== logic/fetch_frontend.sv ====
`timescale 1ns/1ns
`include "frontend_params.svh"

module fetch_frontend (
    input  logic                                              clock,
    input  logic                                              reset,
    input  frontend_pkg::fetch_resp_t                         mem_resp,
    input  frontend_pkg::redirect_t                           redirect,
    input  logic [$clog2(`FE_DISPATCH_WIDTH+1)-1:0]           dispatch_count,
    output frontend_pkg::fetch_req_t                          mem_req,
    output frontend_pkg::decoded_inst_t [`FE_DISPATCH_WIDTH-1:0] dispatch_insts,
    output logic [$clog2(`FE_DISPATCH_WIDTH+1)-1:0]           dispatch_valid_count
);
    logic                                        issue;
    logic                                        load_target;
    logic                                        flush;
    logic                                        outstanding;
    logic [`FE_PC_BITS-1:0]                      fetch_pc;
    logic [$clog2(`FE_BUF_DEPTH+1)-1:0]          open_entries;
    frontend_pkg::inst_packet_t [`FE_DISPATCH_WIDTH-1:0] head_insts;

    assign mem_req = '{valid: issue, addr: fetch_pc};

    fetch_control fetch_control_i (
        .clock       (clock),
        .reset       (reset),
        .redirect    (redirect),
        .open_entries(open_entries),
        .outstanding (outstanding),
        .issue       (issue),
        .load_target (load_target),
        .flush       (flush)
    );

    fetch_pc_counter fetch_pc_counter_i (
        .clock      (clock),
        .reset      (reset),
        .issue      (issue),
        .load_target(load_target),
        .target     (redirect.pc),
        .fetch_pc   (fetch_pc),
        .outstanding(outstanding)
    );

    inst_buffer #(
        .DEPTH(`FE_BUF_DEPTH)
    ) inst_buffer_i (
        .clock         (clock),
        .reset         (reset),
        .flush         (flush),
        .in_resp       (mem_resp),
        .dispatch_count(dispatch_count),
        .head_insts    (head_insts),
        .valid_count   (dispatch_valid_count),
        .open_entries  (open_entries)
    );

    inst_decode inst_decode_i (
        .insts  (head_insts),
        .decoded(dispatch_insts)
    );

endmodule

// ==== logic/inst_decode.sv ====
`timescale 1ns/1ns
`include "frontend_params.svh"

module inst_decode (
    input  frontend_pkg::inst_packet_t  [`FE_DISPATCH_WIDTH-1:0] insts,
    output frontend_pkg::decoded_inst_t [`FE_DISPATCH_WIDTH-1:0] decoded
);
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;

    always_comb begin
        for (int i = 0; i < `FE_DISPATCH_WIDTH; i++) begin
            decoded[i].pc     = insts[i].pc;
            decoded[i].word   = insts[i].word;
            decoded[i].opcode = insts[i].word.r_view.opcode;

            if (insts[i].word.r_view.opcode == OPC_OP_IMM ||
                insts[i].word.r_view.opcode == OPC_LOAD) begin
                // I-type, rs2 slot holds immediate bits
                decoded[i].rd     = insts[i].word.i_view.rd;
                decoded[i].rs1    = insts[i].word.i_view.rs1;
                decoded[i].rs2    = '0;
                decoded[i].is_imm = 1'b1;
                decoded[i].imm    = {{20{insts[i].word.i_view.imm12[11]}},
                                     insts[i].word.i_view.imm12};
            end else begin
                decoded[i].rd     = insts[i].word.r_view.rd;
                decoded[i].rs1    = insts[i].word.r_view.rs1;
                decoded[i].rs2    = insts[i].word.r_view.rs2;
                decoded[i].is_imm = 1'b0;
                decoded[i].imm    = '0;
            end
        end
    end

endmodule

// ==== logic/inst_buffer.sv ====
`timescale 1ns/1ns
`include "frontend_params.svh"

module inst_buffer #(
    parameter int DEPTH = `FE_BUF_DEPTH
) (
    input  logic                                           clock,
    input  logic                                           reset,
    input  logic                                           flush,
    input  frontend_pkg::fetch_resp_t                      in_resp,
    input  logic [$clog2(`FE_DISPATCH_WIDTH+1)-1:0]        dispatch_count,
    output frontend_pkg::inst_packet_t [`FE_DISPATCH_WIDTH-1:0] head_insts,
    output logic [$clog2(`FE_DISPATCH_WIDTH+1)-1:0]        valid_count,
    output logic [$clog2(DEPTH+1)-1:0]                     open_entries
);
    localparam int PTR_BITS   = $clog2(DEPTH);
    localparam int COUNT_BITS = $clog2(DEPTH + 1);
    localparam int FW         = `FE_FETCH_WIDTH;
    localparam int DW         = `FE_DISPATCH_WIDTH;
    localparam int DW_BITS    = $clog2(DW + 1);

    logic [PTR_BITS-1:0]   head;
    logic [PTR_BITS-1:0]   tail;
    logic [COUNT_BITS-1:0] count;
    logic [COUNT_BITS-1:0] accept_count;
    logic                  accept;

    frontend_pkg::inst_packet_t entries [DEPTH];

    // A response in the flush cycle is dropped with the rest
    assign accept       = in_resp.valid && !flush;
    assign accept_count = accept ? COUNT_BITS'(FW) : '0;

    // Space left once this cycle's dispatch has gone
    assign open_entries = COUNT_BITS'(DEPTH) - count + COUNT_BITS'(dispatch_count);

    always_comb begin
        if (count >= COUNT_BITS'(DW)) begin
            valid_count = DW_BITS'(DW);
        end else begin
            valid_count = DW_BITS'(count);
        end
    end

    always_comb begin
        for (int i = 0; i < DW; i++) begin
            head_insts[i] = entries[head + PTR_BITS'(i)];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + PTR_BITS'(dispatch_count);
            tail  <= tail + PTR_BITS'(accept_count);
            count <= count - COUNT_BITS'(dispatch_count) + accept_count;
        end
    end

    // Whole group goes in at the tail, wrapping as needed
    always_ff @(posedge clock) begin
        if (accept) begin
            for (int i = 0; i < FW; i++) begin
                entries[tail + PTR_BITS'(i)] <= '{
                    pc:   in_resp.addr + `FE_PC_BITS'(4 * i),
                    word: in_resp.words[i]
                };
            end
        end
    end

    // Back end may only take what was offered
    assert property (@(posedge clock) disable iff (reset)
        dispatch_count <= valid_count);

    assert property (@(posedge clock) disable iff (reset)
        count <= COUNT_BITS'(DEPTH));

endmodule

// ==== fetch/fetch_pc_counter.sv ====
`timescale 1ns/1ns
`include "frontend_params.svh"

module fetch_pc_counter (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   issue,
    input  logic                   load_target,
    input  logic [`FE_PC_BITS-1:0] target,
    output logic [`FE_PC_BITS-1:0] fetch_pc,
    output logic                   outstanding
);
    localparam int GROUP_BYTES = 4 * `FE_FETCH_WIDTH;
    localparam int OFFSET_BITS = $clog2(GROUP_BYTES);

    logic [`FE_PC_BITS-1:0] aligned_target;

    // Round down to the start of its group
    assign aligned_target = target & ~(`FE_PC_BITS'(GROUP_BYTES - 1));

    always_ff @(posedge clock) begin
        if (reset) begin
            fetch_pc    <= `FE_BOOT_PC;
            outstanding <= 1'b0;
        end else begin
            if (load_target) begin
                fetch_pc <= aligned_target;
            end else if (issue) begin
                fetch_pc <= fetch_pc + `FE_PC_BITS'(GROUP_BYTES);
            end
            // Memory always answers in the next cycle
            outstanding <= issue;
        end
    end

    assert property (@(posedge clock) disable iff (reset)
        fetch_pc[OFFSET_BITS-1:0] == '0);

endmodule

// ==== fetch/fetch_control.sv ====
`timescale 1ns/1ns
`include "frontend_params.svh"

module fetch_control (
    input  logic                                  clock,
    input  logic                                  reset,
    input  frontend_pkg::redirect_t               redirect,
    input  logic [$clog2(`FE_BUF_DEPTH+1)-1:0]    open_entries,
    input  logic                                  outstanding,
    output logic                                  issue,
    output logic                                  load_target,
    output logic                                  flush
);
    localparam int GROUP = `FE_FETCH_WIDTH;

    frontend_pkg::fetch_state_e state;
    frontend_pkg::fetch_state_e next_state;
    logic room;

    // A group in flight lands this cycle, so its slots are already spoken for
    assign room = int'(open_entries) >= GROUP + (outstanding ? GROUP : 0);

    assign flush       = redirect.valid;
    assign load_target = redirect.valid;
    assign issue       = (state == frontend_pkg::RUN) && room && !redirect.valid;

    always_comb begin
        next_state = state;
        if (redirect.valid) begin
            next_state = frontend_pkg::REFILL;
        end else begin
            case (state)
                frontend_pkg::BOOT: begin
                    next_state = frontend_pkg::RUN;
                end
                frontend_pkg::RUN: begin
                    if (!room) begin
                        next_state = frontend_pkg::FULL;
                    end
                end
                frontend_pkg::FULL: begin
                    if (room) begin
                        next_state = frontend_pkg::RUN;
                    end
                end
                frontend_pkg::REFILL: begin
                    next_state = frontend_pkg::RUN;
                end
                default: begin
                    next_state = frontend_pkg::BOOT;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= frontend_pkg::BOOT;
        end else begin
            state <= next_state;
        end
    end

    // Buffer never reports more space than it holds
    assert property (@(posedge clock) disable iff (reset)
        int'(open_entries) <= `FE_BUF_DEPTH);

    // Every request counts as in flight in the next cycle
    assert property (@(posedge clock) disable iff (reset)
        issue |=> outstanding);

endmodule

// ==== common/frontend_pkg.sv ====
`include "frontend_params.svh"

package frontend_pkg;

    // Register-register layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    // Immediate layout
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
    } inst_word_u;

    typedef struct packed {
        logic [`FE_PC_BITS-1:0] pc;
        inst_word_u             word;
    } inst_packet_t;

    typedef struct packed {
        logic                   valid;
        logic [`FE_PC_BITS-1:0] addr;
    } fetch_req_t;

    // Word 0 sits at addr, word i at addr + 4i
    typedef struct packed {
        logic                                valid;
        logic [`FE_PC_BITS-1:0]              addr;
        inst_word_u [`FE_FETCH_WIDTH-1:0]    words;
    } fetch_resp_t;

    typedef struct packed {
        logic                   valid;
        logic [`FE_PC_BITS-1:0] pc;
    } redirect_t;

    typedef struct packed {
        logic [`FE_PC_BITS-1:0] pc;
        inst_word_u             word;
        logic [6:0]             opcode;
        logic [4:0]             rd;
        logic [4:0]             rs1;
        logic [4:0]             rs2;
        logic                   is_imm;
        logic [31:0]            imm;
    } decoded_inst_t;

    typedef enum logic [1:0] {
        BOOT,
        RUN,
        FULL,
        REFILL
    } fetch_state_e;

endpackage

// ==== common/frontend_params.svh ====
`ifndef FRONTEND_PARAMS_SVH
`define FRONTEND_PARAMS_SVH

// Words per fetch group
`define FE_FETCH_WIDTH 4

// Entries presented to the back end each cycle
`define FE_DISPATCH_WIDTH 2

// Power of two, at least twice the fetch width
`define FE_BUF_DEPTH 8

`define FE_BOOT_PC 32'h0000_1000

`define FE_PC_BITS 32

`endif
